/* verilog/jfive_pkg.sv */
package jfive_pkg;

    localparam int XLEN          = 32;
    localparam int PC_BITS       = 32;
    localparam int INSTR_BITS    = 32;
    localparam int MEM_ADDR_BITS = 10;
    localparam int STRB_BITS     = XLEN / 8;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [PC_BITS-1:0] pc;
        logic [XLEN-1:0]    rs1_val;
        logic [XLEN-1:0]    rs2_val;
        logic [XLEN-1:0]    imm;
        reg_idx_t           rd;
        alu_op_e            alu_op;
        logic               use_imm;
        logic               reg_we;
        logic               is_load;
        logic               is_store;
        logic               is_branch;
        logic               branch_on_equal;
    } decoded_t;

    typedef struct packed {
        reg_idx_t           rd;
        logic [XLEN-1:0]    value;
        logic               reg_we;
        logic               is_load;
        logic               branch_taken;
        logic [PC_BITS-1:0] next_pc;
    } exec_res_t;

    // tags that ride beside the RAM read latency
    typedef logic [PC_BITS-1:0] ibus_tag_t;
    typedef reg_idx_t           dbus_tag_t;

    typedef struct packed {
        logic [MEM_ADDR_BITS-1:0] addr;
        logic                     wr;
        logic [STRB_BITS-1:0]     strb;
        logic [XLEN-1:0]          wdata;
    } dbus_cmd_t;

endpackage

/* verilog/jfive_mem_pipe.sv */
`timescale 1ns/100ps

module jfive_mem_pipe #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    logic     st0_valid;
    payload_t st0_payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
            out_valid <= 1'b0;
        end else if (enable) begin
            st0_valid <= in_valid;
            out_valid <= st0_valid;
        end
    end

    // payload follows valid, two stages like the RAM read
    always_ff @(posedge clk) begin
        if (enable) begin
            st0_payload <= in_payload;
            out_payload <= st0_payload;
        end
    end

endmodule

/* verilog/jfive_ram.sv */
`timescale 1ns/100ps

module jfive_ram (
    input  logic                                clk,
    input  logic                                enable,
    input  logic [jfive_pkg::MEM_ADDR_BITS-1:0] port0_addr,
    output logic [jfive_pkg::XLEN-1:0]          port0_dout,
    input  logic [3:0]                          port1_we,
    input  logic [jfive_pkg::MEM_ADDR_BITS-1:0] port1_addr,
    input  logic [jfive_pkg::XLEN-1:0]          port1_din,
    output logic [jfive_pkg::XLEN-1:0]          port1_dout
);

    localparam int WORDS = 2 ** jfive_pkg::MEM_ADDR_BITS;

    logic [jfive_pkg::XLEN-1:0] mem [0:WORDS-1];
    logic [jfive_pkg::XLEN-1:0] port0_st0;
    logic [jfive_pkg::XLEN-1:0] port1_st0;

    // byte lane writes, port 1 only
    always_ff @(posedge clk) begin
        if (enable) begin
            for (int i = 0; i < 4; i++) begin
                if (port1_we[i]) begin
                    mem[port1_addr][i*8 +: 8] <= port1_din[i*8 +: 8];
                end
            end
        end
    end

    // port 0 read, two register stages
    always_ff @(posedge clk) begin
        if (enable) begin
            port0_st0  <= mem[port0_addr];
            port0_dout <= port0_st0;
        end
    end

    // port 1 read returns the old word on a write
    always_ff @(posedge clk) begin
        if (enable) begin
            port1_st0  <= mem[port1_addr];
            port1_dout <= port1_st0;
        end
    end

endmodule

/* verilog/jfive_fetch.sv */
`timescale 1ns/100ps

module jfive_fetch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          retire,
    input  logic [jfive_pkg::PC_BITS-1:0] next_pc,
    output logic                          ibus_cmd_valid,
    output logic [jfive_pkg::PC_BITS-1:0] ibus_cmd_pc,
    input  logic                          ibus_cmd_acceptable
);

    logic [jfive_pkg::PC_BITS-1:0] pc;
    logic                          busy;

    // one instruction in flight at a time
    assign ibus_cmd_valid = run && !busy;
    assign ibus_cmd_pc    = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= '0;
            busy <= 1'b0;
        end else if (retire) begin
            pc   <= next_pc;
            busy <= 1'b0;
        end else if (ibus_cmd_valid && ibus_cmd_acceptable) begin
            busy <= 1'b1;
        end
    end

endmodule

/* verilog/jfive_decode.sv */
`timescale 1ns/100ps

module jfive_decode (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             ibus_res_valid,
    input  logic [jfive_pkg::PC_BITS-1:0]    ibus_res_pc,
    input  logic [jfive_pkg::INSTR_BITS-1:0] ibus_res_instr,
    input  logic                             wb_we,
    input  jfive_pkg::reg_idx_t              wb_rd,
    input  logic [jfive_pkg::XLEN-1:0]       wb_value,
    output logic                             dec_valid,
    output jfive_pkg::decoded_t              dec
);

    logic [jfive_pkg::XLEN-1:0] regs [1:31];
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    jfive_pkg::reg_idx_t        rs1;
    jfive_pkg::reg_idx_t        rs2;
    logic [jfive_pkg::XLEN-1:0] imm_i;
    logic [jfive_pkg::XLEN-1:0] imm_s;
    logic [jfive_pkg::XLEN-1:0] imm_b;
    logic [jfive_pkg::XLEN-1:0] imm_u;
    jfive_pkg::alu_op_e         f3_alu;
    logic                       f3_ok;
    jfive_pkg::decoded_t        dec_next;

    assign opcode = ibus_res_instr[6:0];
    assign funct3 = ibus_res_instr[14:12];
    assign rs1    = ibus_res_instr[19:15];
    assign rs2    = ibus_res_instr[24:20];

    assign imm_i = {{20{ibus_res_instr[31]}}, ibus_res_instr[31:20]};
    assign imm_s = {{20{ibus_res_instr[31]}}, ibus_res_instr[31:25], ibus_res_instr[11:7]};
    assign imm_b = {{19{ibus_res_instr[31]}}, ibus_res_instr[31], ibus_res_instr[7],
                    ibus_res_instr[30:25], ibus_res_instr[11:8], 1'b0};
    assign imm_u = {ibus_res_instr[31:12], 12'b0};

    // x0 is not stored
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // funct3 map shared by OP and OP_IMM, bit 30 picks SUB on OP
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000: f3_alu = (opcode == jfive_pkg::OPC_OP && ibus_res_instr[30]) ?
                             jfive_pkg::ALU_SUB : jfive_pkg::ALU_ADD;
            3'b100: f3_alu = jfive_pkg::ALU_XOR;
            3'b110: f3_alu = jfive_pkg::ALU_OR;
            3'b111: f3_alu = jfive_pkg::ALU_AND;
            default: begin
                f3_alu = jfive_pkg::ALU_ADD;
                f3_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_next         = '0;
        dec_next.pc      = ibus_res_pc;
        dec_next.rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
        dec_next.rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
        dec_next.rd      = ibus_res_instr[11:7];
        dec_next.alu_op  = f3_alu;
        case (opcode)
            jfive_pkg::OPC_OP_IMM: begin
                dec_next.imm     = imm_i;
                dec_next.use_imm = 1'b1;
                dec_next.reg_we  = f3_ok;
            end
            jfive_pkg::OPC_OP: dec_next.reg_we = f3_ok;
            jfive_pkg::OPC_LUI: begin
                dec_next.imm     = imm_u;
                dec_next.use_imm = 1'b1;
                dec_next.alu_op  = jfive_pkg::ALU_PASS_B;
                dec_next.reg_we  = 1'b1;
            end
            jfive_pkg::OPC_LOAD: begin
                dec_next.imm     = imm_i;
                dec_next.reg_we  = 1'b1;
                dec_next.is_load = (funct3 == 3'b010);
            end
            jfive_pkg::OPC_STORE: begin
                dec_next.imm      = imm_s;
                dec_next.is_store = (funct3 == 3'b010);
            end
            jfive_pkg::OPC_BRANCH: begin
                dec_next.imm             = imm_b;
                dec_next.is_branch       = (funct3[2:1] == 2'b00);
                dec_next.branch_on_equal = !funct3[0];
            end
            // anything else passes through as a no-op
            default: dec_next.alu_op = jfive_pkg::ALU_ADD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= ibus_res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ibus_res_valid) begin
            dec <= dec_next;
        end
    end

endmodule

/* verilog/jfive_execute.sv */
`timescale 1ns/100ps

module jfive_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  jfive_pkg::decoded_t  dec,
    output logic                 exe_valid,
    output jfive_pkg::exec_res_t exe,
    output logic                 dbus_cmd_valid,
    output jfive_pkg::dbus_cmd_t dbus_cmd,
    output jfive_pkg::dbus_tag_t dbus_tag,
    input  logic                 dbus_cmd_acceptable
);

    logic [jfive_pkg::XLEN-1:0]    operand_b;
    logic [jfive_pkg::XLEN-1:0]    alu_value;
    logic [jfive_pkg::XLEN-1:0]    mem_byte_addr;
    logic [jfive_pkg::PC_BITS-1:0] target_pc;
    logic                          branch_taken;

    assign operand_b = dec.use_imm ? dec.imm : dec.rs2_val;

    always_comb begin
        case (dec.alu_op)
            jfive_pkg::ALU_SUB:    alu_value = dec.rs1_val - operand_b;
            jfive_pkg::ALU_AND:    alu_value = dec.rs1_val & operand_b;
            jfive_pkg::ALU_OR:     alu_value = dec.rs1_val | operand_b;
            jfive_pkg::ALU_XOR:    alu_value = dec.rs1_val ^ operand_b;
            jfive_pkg::ALU_PASS_B: alu_value = operand_b;
            default:               alu_value = dec.rs1_val + operand_b;
        endcase
    end

    // byte address, the bus takes the word part
    assign mem_byte_addr = dec.rs1_val + dec.imm;

    assign branch_taken = dec.is_branch &&
                          ((dec.rs1_val == dec.rs2_val) == dec.branch_on_equal);
    assign target_pc    = branch_taken ? dec.pc + dec.imm : dec.pc + 4;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid      <= 1'b0;
            dbus_cmd_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
            if (dec_valid) begin
                dbus_cmd_valid <= dec.is_load || dec.is_store;
            end else if (dbus_cmd_acceptable) begin
                dbus_cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe.rd           <= dec.rd;
            exe.value        <= alu_value;
            exe.reg_we       <= dec.reg_we;
            exe.is_load      <= dec.is_load;
            exe.branch_taken <= branch_taken;
            exe.next_pc      <= target_pc;
            dbus_cmd.addr    <= mem_byte_addr[jfive_pkg::MEM_ADDR_BITS+1:2];
            dbus_cmd.wr      <= dec.is_store;
            dbus_cmd.strb    <= dec.is_store ? '1 : '0;
            dbus_cmd.wdata   <= dec.rs2_val;
            dbus_tag         <= dec.rd;
        end
    end

endmodule

/* verilog/jfive_result.sv */
`timescale 1ns/100ps

module jfive_result (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          exe_valid,
    input  jfive_pkg::exec_res_t          exe,
    input  logic                          dbus_res_valid,
    input  logic [jfive_pkg::XLEN-1:0]    dbus_res_rdata,
    input  jfive_pkg::dbus_tag_t          dbus_res_tag,
    output logic                          wb_we,
    output jfive_pkg::reg_idx_t           wb_rd,
    output logic [jfive_pkg::XLEN-1:0]    wb_value,
    output logic                          retire,
    output logic [jfive_pkg::PC_BITS-1:0] next_pc
);

    logic load_wait;
    logic load_done;

    assign load_done = load_wait && dbus_res_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we     <= 1'b0;
            retire    <= 1'b0;
            load_wait <= 1'b0;
        end else begin
            wb_we  <= 1'b0;
            retire <= 1'b0;
            if (exe_valid && !exe.is_load) begin
                wb_we  <= exe.reg_we && exe.rd != 5'd0;
                retire <= 1'b1;
            end
            if (exe_valid && exe.is_load) begin
                load_wait <= 1'b1;
            end
            if (load_done) begin
                wb_we     <= dbus_res_tag != 5'd0;
                retire    <= 1'b1;
                load_wait <= 1'b0;
            end
        end
    end

    // next_pc is held while a load is outstanding
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            next_pc <= exe.next_pc;
        end
        if (exe_valid && !exe.is_load) begin
            wb_rd    <= exe.rd;
            wb_value <= exe.value;
        end else if (load_done) begin
            wb_rd    <= dbus_res_tag;
            wb_value <= dbus_res_rdata;
        end
    end

endmodule

/* verilog/jfive_core.sv */
`timescale 1ns/100ps

module jfive_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             run,
    output logic                             ibus_cmd_valid,
    output logic [jfive_pkg::PC_BITS-1:0]    ibus_cmd_pc,
    input  logic                             ibus_cmd_acceptable,
    input  logic                             ibus_res_valid,
    input  logic [jfive_pkg::PC_BITS-1:0]    ibus_res_pc,
    input  logic [jfive_pkg::INSTR_BITS-1:0] ibus_res_instr,
    output logic                             ibus_res_acceptable,
    output logic                             dbus_cmd_valid,
    output jfive_pkg::dbus_cmd_t             dbus_cmd,
    output jfive_pkg::dbus_tag_t             dbus_cmd_tag,
    input  logic                             dbus_cmd_acceptable,
    input  logic                             dbus_res_valid,
    input  logic [jfive_pkg::XLEN-1:0]       dbus_res_rdata,
    input  jfive_pkg::dbus_tag_t             dbus_res_tag,
    output logic                             dbus_res_acceptable
);

    logic                          retire;
    logic [jfive_pkg::PC_BITS-1:0] next_pc;
    logic                          wb_we;
    jfive_pkg::reg_idx_t           wb_rd;
    logic [jfive_pkg::XLEN-1:0]    wb_value;
    logic                          dec_valid;
    jfive_pkg::decoded_t           dec;
    logic                          exe_valid;
    jfive_pkg::exec_res_t          exe;

    // results are always taken
    assign ibus_res_acceptable = 1'b1;
    assign dbus_res_acceptable = 1'b1;

    jfive_fetch fetch_inst (
        .clk, .reset, .run, .retire, .next_pc,
        .ibus_cmd_valid, .ibus_cmd_pc, .ibus_cmd_acceptable
    );

    jfive_decode decode_inst (
        .clk, .reset, .ibus_res_valid, .ibus_res_pc, .ibus_res_instr,
        .wb_we, .wb_rd, .wb_value, .dec_valid, .dec
    );

    jfive_execute execute_inst (
        .clk, .reset, .dec_valid, .dec, .exe_valid, .exe,
        .dbus_cmd_valid, .dbus_cmd, .dbus_tag(dbus_cmd_tag), .dbus_cmd_acceptable
    );

    jfive_result result_inst (
        .clk, .reset, .exe_valid, .exe, .dbus_res_valid, .dbus_res_rdata, .dbus_res_tag,
        .wb_we, .wb_rd, .wb_value, .retire, .next_pc
    );

endmodule

/* verilog/jfive_lite.sv */
`timescale 1ns/100ps

module jfive_lite (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                host_we,
    input  logic [jfive_pkg::MEM_ADDR_BITS-1:0] host_addr,
    input  logic [jfive_pkg::XLEN-1:0]          host_data,
    output logic                                store_valid,
    output logic [jfive_pkg::MEM_ADDR_BITS-1:0] store_addr,
    output logic [jfive_pkg::XLEN-1:0]          store_data
);

    logic                             ibus_cmd_valid;
    logic [jfive_pkg::PC_BITS-1:0]    ibus_cmd_pc;
    logic                             ibus_cmd_acceptable;
    logic                             ibus_res_valid;
    jfive_pkg::ibus_tag_t             ibus_res_pc;
    logic [jfive_pkg::INSTR_BITS-1:0] ibus_res_instr;
    logic                             ibus_res_acceptable;
    logic                             dbus_cmd_valid;
    jfive_pkg::dbus_cmd_t             dbus_cmd;
    jfive_pkg::dbus_tag_t             dbus_cmd_tag;
    logic                             dbus_cmd_acceptable;
    logic                             dbus_res_valid;
    logic [jfive_pkg::XLEN-1:0]       dbus_res_rdata;
    jfive_pkg::dbus_tag_t             dbus_res_tag;
    logic                             dbus_res_acceptable;
    logic                             mem_enable;
    logic                             dbus_write;
    logic [3:0]                       port1_we;
    logic [jfive_pkg::MEM_ADDR_BITS-1:0] port1_addr;
    logic [jfive_pkg::XLEN-1:0]       port1_din;

    jfive_core core_inst (.*);

    assign ibus_cmd_acceptable = ibus_res_acceptable;
    assign dbus_cmd_acceptable = dbus_res_acceptable;
    assign mem_enable          = ibus_res_acceptable && dbus_res_acceptable;

    assign dbus_write = run && dbus_cmd_valid && dbus_cmd.wr && dbus_cmd_acceptable;

    // host owns port 1 while the core is stopped
    assign port1_we   = run ? (dbus_write ? dbus_cmd.strb : 4'h0) : {4{host_we}};
    assign port1_addr = run ? dbus_cmd.addr : host_addr;
    assign port1_din  = run ? dbus_cmd.wdata : host_data;

    jfive_ram ram_inst (
        .clk,
        .enable     (mem_enable),
        .port0_addr (ibus_cmd_pc[jfive_pkg::MEM_ADDR_BITS+1:2]),
        .port0_dout (ibus_res_instr),
        .port1_we,
        .port1_addr,
        .port1_din,
        .port1_dout (dbus_res_rdata)
    );

    jfive_mem_pipe #(.payload_t(jfive_pkg::ibus_tag_t)) ibus_pipe_inst (
        .clk, .reset,
        .enable      (ibus_res_acceptable),
        .in_valid    (ibus_cmd_valid && ibus_cmd_acceptable),
        .in_payload  (ibus_cmd_pc),
        .out_valid   (ibus_res_valid),
        .out_payload (ibus_res_pc)
    );

    // only reads come back on the data side
    jfive_mem_pipe #(.payload_t(jfive_pkg::dbus_tag_t)) dbus_pipe_inst (
        .clk, .reset,
        .enable      (dbus_res_acceptable),
        .in_valid    (dbus_cmd_valid && dbus_cmd_acceptable && !dbus_cmd.wr),
        .in_payload  (dbus_cmd_tag),
        .out_valid   (dbus_res_valid),
        .out_payload (dbus_res_tag)
    );

    assign store_valid = dbus_write;
    assign store_addr  = dbus_cmd.addr;
    assign store_data  = dbus_cmd.wdata;

endmodule

/* testbench/jfive_lite_tb.sv */
`timescale 1ns/100ps

module jfive_lite_tb;

    // each test takes well under 200 cycles including load and reset
    localparam int TIMEOUT_CYCLES = 2000;
    // sw x0, -4(x0) marks the end of every program
    localparam logic [9:0] SENTINEL_WORD = 10'h3ff;

    logic        clk;
    logic        reset;
    logic        run;
    logic        host_we;
    logic [9:0]  host_addr;
    logic [31:0] host_data;
    logic        store_valid;
    logic [9:0]  store_addr;
    logic [31:0] store_data;

    integer      seed;
    int          cycle_count;
    logic [31:0] prog[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [31:0] got_addr[$];
    logic [31:0] got_data[$];

    jfive_lite jfive_lite_inst (
        .clk,
        .reset,
        .run,
        .host_we,
        .host_addr,
        .host_data,
        .store_valid,
        .store_addr,
        .store_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on timeout");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    // instruction encoders with opcodes from the ISA tables
    function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // imm is the signed byte offset from the branch itself
    function automatic logic [31:0] branch_instr(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;
        emit(lui_instr(rd, rounded[31:12]));
        emit(alu_imm(3'b000, rd, rd, value[11:0]));
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic end_program();
        emit(sw_instr(5'd0, 5'd0, 12'hffc));
        emit(branch_instr(3'b000, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic expect_store(input logic [31:0] byte_addr, input logic [31:0] data);
        exp_addr.push_back(byte_addr >> 2);
        exp_data.push_back(data);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    // host port owns RAM port 1 while run is low
    task automatic load_program();
        @(posedge clk);
        #1 run = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            host_we   = 1'b1;
            host_addr = 10'(i);
            host_data = prog[i];
            @(posedge clk);
            #1;
        end
        host_we = 1'b0;
        reset_dut();
    endtask

    // collect store events until the end marker shows up
    task automatic run_program();
        logic done;
        done = 1'b0;
        got_addr.delete();
        got_data.delete();
        @(posedge clk);
        #1 run = 1'b1;
        while (!done) begin
            @(negedge clk);
            if (store_valid) begin
                if (store_addr == SENTINEL_WORD) begin
                    done = 1'b1;
                end else begin
                    got_addr.push_back({22'd0, store_addr});
                    got_data.push_back(store_data);
                end
            end
        end
        @(posedge clk);
        #1 run = 1'b0;
    endtask

    task automatic compare_stores();
        check_value("store count", got_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value($sformatf("store_addr[%0d]", i), got_addr[i], exp_addr[i]);
            check_value($sformatf("store_data[%0d]", i), got_data[i], exp_data[i]);
        end
    endtask

    task automatic test_imm_ops();
        logic [31:0] base;
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [31:0] sx;
        logic [2:0]  f3;
        logic [31:0] expected;
        $display("test: immediate ALU ops");
        new_program();
        base = $random(seed);
        load_const(5'd1, base);
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            imm = rnd[11:0];
            sx  = {{20{imm[11]}}, imm};
            case (i)
                0: begin
                    f3       = 3'b000;
                    expected = base + sx;
                end
                1: begin
                    f3       = 3'b111;
                    expected = base & sx;
                end
                2: begin
                    f3       = 3'b110;
                    expected = base | sx;
                end
                default: begin
                    f3       = 3'b100;
                    expected = base ^ sx;
                end
            endcase
            emit(alu_imm(f3, 5'd2, 5'd1, imm));
            emit(sw_instr(5'd2, 5'd0, 12'h100 + 12'(4 * i)));
            expect_store(32'h100 + 32'(4 * i), expected);
        end
        end_program();
        load_program();
        run_program();
        compare_stores();
    endtask

    task automatic test_reg_ops();
        logic [31:0] a;
        logic [31:0] b;
        $display("test: register ALU ops and LUI");
        new_program();
        // a below b so SUB wraps
        a = 32'h0f0f1234;
        b = 32'h7a5a9876;
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(alu_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(sw_instr(5'd3, 5'd0, 12'h180));
        emit(alu_reg(7'h20, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(sw_instr(5'd3, 5'd0, 12'h184));
        emit(alu_reg(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
        emit(sw_instr(5'd3, 5'd0, 12'h188));
        emit(alu_reg(7'h00, 3'b110, 5'd3, 5'd1, 5'd2));
        emit(sw_instr(5'd3, 5'd0, 12'h18c));
        emit(alu_reg(7'h00, 3'b100, 5'd3, 5'd1, 5'd2));
        emit(sw_instr(5'd3, 5'd0, 12'h190));
        emit(lui_instr(5'd3, 20'habcde));
        emit(sw_instr(5'd3, 5'd0, 12'h194));
        end_program();
        expect_store(32'h180, a + b);
        expect_store(32'h184, a - b);
        expect_store(32'h188, a & b);
        expect_store(32'h18c, a | b);
        expect_store(32'h190, a ^ b);
        expect_store(32'h194, 32'habcde000);
        load_program();
        run_program();
        compare_stores();
    endtask

    task automatic test_load_store();
        logic [31:0] value;
        $display("test: load after store");
        new_program();
        value = $random(seed);
        load_const(5'd1, value);
        emit(sw_instr(5'd1, 5'd0, 12'h140));
        emit(lw_instr(5'd2, 5'd0, 12'h140));
        emit(alu_imm(3'b000, 5'd3, 5'd2, 12'd1));
        emit(sw_instr(5'd3, 5'd0, 12'h144));
        end_program();
        expect_store(32'h140, value);
        expect_store(32'h144, value + 32'd1);
        load_program();
        run_program();
        compare_stores();
    endtask

    task automatic test_branch_loop();
        $display("test: branch loop");
        new_program();
        emit(alu_imm(3'b000, 5'd1, 5'd0, 12'd5));
        // loop body at byte 4
        emit(sw_instr(5'd1, 5'd0, 12'h200));
        emit(alu_imm(3'b000, 5'd1, 5'd1, 12'hfff));
        emit(branch_instr(3'b001, 5'd1, 5'd0, 13'h1ff8));
        // taken BEQ jumps over the next store
        emit(branch_instr(3'b000, 5'd0, 5'd0, 13'd8));
        emit(sw_instr(5'd1, 5'd0, 12'h300));
        end_program();
        for (int n = 5; n > 0; n--) begin
            expect_store(32'h200, 32'(n));
        end
        load_program();
        run_program();
        compare_stores();
    endtask

    task automatic test_x0();
        $display("test: register x0");
        new_program();
        emit(alu_imm(3'b000, 5'd1, 5'd0, 12'd7));
        emit(alu_imm(3'b000, 5'd0, 5'd0, 12'd123));
        emit(alu_reg(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(sw_instr(5'd0, 5'd0, 12'h020));
        emit(sw_instr(5'd1, 5'd0, 12'h024));
        end_program();
        expect_store(32'h020, 32'd0);
        expect_store(32'h024, 32'd7);
        load_program();
        run_program();
        compare_stores();
    endtask

    // RAM still holds the x0 program, which has to start from pc 0 once run rises
    task automatic test_run_low();
        int stores;
        $display("test: run held low");
        stores = 0;
        @(posedge clk);
        #1 run = 1'b0;
        reset = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (store_valid) begin
                stores++;
            end
        end
        @(posedge clk);
        #1 reset = 1'b0;
        repeat (40) begin
            @(negedge clk);
            if (store_valid) begin
                stores++;
            end
        end
        check_value("store_valid count with run low", stores, 32'd0);
        run_program();
        compare_stores();
    endtask

    initial begin
        seed      = 33843;
        reset     = 1'b1;
        run       = 1'b0;
        host_we   = 1'b0;
        host_addr = '0;
        host_data = '0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        test_imm_ops();
        test_reg_ops();
        test_load_store();
        test_branch_loop();
        test_x0();
        test_run_low();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* jfive_lite.f */
verilog/jfive_pkg.sv
verilog/jfive_mem_pipe.sv
verilog/jfive_ram.sv
verilog/jfive_fetch.sv
verilog/jfive_decode.sv
verilog/jfive_execute.sv
verilog/jfive_result.sv
verilog/jfive_core.sv
verilog/jfive_lite.sv
testbench/jfive_lite_tb.sv

/* build.sh */
#!/usr/bin/env bash
# compile and run the jfive_lite testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module jfive_lite_tb -f jfive_lite.f \
    --Mdir obj_dir -o jfive_lite_sim
if [ $? -ne 0 ]; then
    echo "build: Verilator compile failed"
    exit 1
fi

./obj_dir/jfive_lite_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "build: simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "build: simulator exited with status $sim_status"
    exit 1
fi
exit 0
